//--- exec_input.txt
// inst ctrl reg1 reg2 op1 op2 op1_jump op2_jump mem_rdata int_addr, then expected:
// mem_raddr mem_waddr mem_wdata flags reg_wdata jump_addr
// ctrl: [12] int_assert [8] reg_we [4:0] reg_waddr; flags: [12] jump [8] reg_we [4] we [0] req
003100b3 101 7fffffff 1 7fffffff 1 0 0 0 0 0 0 0 100 80000000 0
fff10093 102 0 0 0 ffffffff 0 0 0 0 0 0 0 100 ffffffff 0
403100b3 103 0 1 0 1 0 0 0 0 0 0 0 100 ffffffff 0
003120b3 104 80000000 1 80000000 1 0 0 0 0 0 0 0 100 1 0
003130b3 105 80000000 1 80000000 1 0 0 0 0 0 0 0 100 0 0
003140b3 6 f0f0f0f0 ff00ff00 f0f0f0f0 ff00ff00 0 0 0 0 0 0 0 0 0ff00ff0 0
003160b3 107 f0f0f0f0 0f0f0000 f0f0f0f0 0f0f0000 0 0 0 0 0 0 0 100 fffff0f0 0
003170b3 108 f0f0f0f0 ff00ff00 f0f0f0f0 ff00ff00 0 0 0 0 0 0 0 100 f000f000 0
003110b3 109 1 3f 1 3f 0 0 0 0 0 0 0 100 80000000 0
003150b3 10a 80000000 1f 80000000 1f 0 0 0 0 0 0 0 100 1 0
403150b3 10b 80000000 4 80000000 4 0 0 0 0 0 0 0 100 f8000000 0
41f15093 10c 80000001 0 80000001 41f 0 0 0 0 0 0 0 100 ffffffff 0
00411093 11f f 0 f 4 0 0 0 0 0 0 0 100 f0 0
// branches, taken then not taken
00310063 0 5 5 5 5 100 20 0 0 0 0 0 1000 0 120
00310063 0 5 6 5 6 100 20 0 0 0 0 0 0 0 0
00311063 0 5 6 5 6 100 20 0 0 0 0 0 1000 0 120
00311063 0 5 5 5 5 100 20 0 0 0 0 0 0 0 0
00314063 0 ffffffff 1 ffffffff 1 100 20 0 0 0 0 0 1000 0 120
00314063 0 1 ffffffff 1 ffffffff 100 20 0 0 0 0 0 0 0 0
00315063 0 1 ffffffff 1 ffffffff 100 20 0 0 0 0 0 1000 0 120
00315063 0 ffffffff 1 ffffffff 1 100 20 0 0 0 0 0 0 0 0
00316063 0 1 ffffffff 1 ffffffff 100 20 0 0 0 0 0 1000 0 120
00316063 0 ffffffff 1 ffffffff 1 100 20 0 0 0 0 0 0 0 0
00317063 0 ffffffff 1 ffffffff 1 100 20 0 0 0 0 0 1000 0 120
00317063 0 1 ffffffff 1 ffffffff 100 20 0 0 0 0 0 0 0 0
// jal, jalr, fence, lui, auipc
000000ef 101 0 0 1000 4 1000 800 0 0 0 0 0 1100 1004 1800
000100e7 101 3000 0 2000 4 3000 10 0 0 0 0 0 1100 2004 3010
0000000f 0 0 0 0 0 4000 4 0 0 0 0 0 1000 0 4004
123450b7 101 0 0 0 12345000 0 0 0 0 0 0 0 100 12345000 0
00001097 101 0 0 400 1000 0 0 0 0 0 0 0 100 1400 0
// loads: lb, lbu, lh, lhu, lw
00010083 101 1000 0 1000 0 0 0 80ff7f01 0 1000 0 0 101 1 0
00010083 101 1000 0 1000 1 0 0 80ff7f01 0 1001 0 0 101 7f 0
00010083 101 1000 0 1000 2 0 0 80ff7f01 0 1002 0 0 101 ffffffff 0
00010083 101 1000 0 1000 3 0 0 80ff7f01 0 1003 0 0 101 ffffff80 0
00014083 101 1000 0 1000 0 0 0 80ff7f01 0 1000 0 0 101 1 0
00014083 101 1000 0 1000 1 0 0 80ff7f01 0 1001 0 0 101 7f 0
00014083 101 1000 0 1000 2 0 0 80ff7f01 0 1002 0 0 101 ff 0
00014083 101 1000 0 1000 3 0 0 80ff7f01 0 1003 0 0 101 80 0
00011083 101 1000 0 1000 0 0 0 80ff7f01 0 1000 0 0 101 7f01 0
00011083 101 1000 0 1000 2 0 0 80ff7f01 0 1002 0 0 101 ffff80ff 0
00015083 101 1000 0 1000 0 0 0 80ff7f01 0 1000 0 0 101 7f01 0
00015083 101 1000 0 1000 2 0 0 80ff7f01 0 1002 0 0 101 80ff 0
00012083 101 1000 0 1000 0 0 0 80ff7f01 0 1000 0 0 101 80ff7f01 0
// stores: sb, sh, sw
00310023 0 2000 11223344 2000 0 0 0 aabbccdd 0 2000 2000 aabbcc44 11 0 0
00310023 0 2000 11223344 2000 1 0 0 aabbccdd 0 2001 2001 aabb44dd 11 0 0
00310023 0 2000 11223344 2000 2 0 0 aabbccdd 0 2002 2002 aa44ccdd 11 0 0
00310023 0 2000 11223344 2000 3 0 0 aabbccdd 0 2003 2003 44bbccdd 11 0 0
00311023 0 2000 11223344 2000 0 0 0 aabbccdd 0 2000 2000 aabb3344 11 0 0
00311023 0 2000 11223344 2000 2 0 0 aabbccdd 0 2002 2002 3344ccdd 11 0 0
00312023 0 2000 11223344 2000 0 0 0 aabbccdd 0 2000 2000 11223344 11 0 0
// interrupt on store, alu and taken branch
00312023 1000 2000 11223344 2000 0 0 0 aabbccdd 80 2000 2000 11223344 1000 0 80
003100b3 1101 3 4 3 4 0 0 0 80 0 0 0 1000 7 80
00310063 1000 5 5 5 5 100 20 0 80 0 0 0 1000 0 80
// end marker
ffffffff

//--- verilog.f
+incdir+.
rv_exec_pkg.sv
exec_alu.sv
exec_branch.sv
exec_lsu.sv
exec_retire.sv
exec_stage.sv
tb_exec_checker.sv
tb_exec_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_stage
RTL_TOP   ?= exec_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
SRCS      ?= $(wildcard *.sv *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_exec_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module tb_exec_stage;
    import rv_exec_pkg::*;

    localparam int WORDS   = 16;            // hex words per vector line
    localparam int MAX_VEC = 64;

    logic             clk;
    logic             rst_n;
    rv_inst_u         inst;
    logic             reg_we;
    logic [4:0]       reg_waddr;
    logic [`XLEN-1:0] reg1_rdata;
    logic [`XLEN-1:0] reg2_rdata;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] op1_jump;
    logic [`XLEN-1:0] op2_jump;
    logic [`XLEN-1:0] mem_rdata;
    logic             int_assert;
    logic [`XLEN-1:0] int_addr;

    logic [`XLEN-1:0] mem_raddr;
    logic [`XLEN-1:0] mem_waddr;
    logic [`XLEN-1:0] mem_wdata;
    logic             mem_we;
    logic             mem_req;
    logic             reg_we_q;
    logic [4:0]       reg_waddr_q;
    logic [`XLEN-1:0] reg_wdata_q;
    logic             jump_flag;
    logic [`XLEN-1:0] jump_addr;

    logic             exp_valid;
    logic [`XLEN-1:0] exp_mem_raddr;
    logic [`XLEN-1:0] exp_mem_waddr;
    logic [`XLEN-1:0] exp_mem_wdata;
    logic             exp_mem_we;
    logic             exp_mem_req;
    logic             exp_reg_we;
    logic [4:0]       exp_reg_waddr;
    logic [`XLEN-1:0] exp_reg_wdata;
    logic             exp_jump_flag;
    logic [`XLEN-1:0] exp_jump_addr;

    logic [31:0] vec_mem [0:MAX_VEC*WORDS-1];
    int          num_vec = 0;
    int          cycle_limit = 0;
    int          cycles = 0;
    int          mem_errors;
    int          ret_errors;

    exec_stage exec_stage_inst (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_i       (inst),
        .reg_we_i     (reg_we),
        .reg_waddr_i  (reg_waddr),
        .reg1_rdata_i (reg1_rdata),
        .reg2_rdata_i (reg2_rdata),
        .op1_i        (op1),
        .op2_i        (op2),
        .op1_jump_i   (op1_jump),
        .op2_jump_i   (op2_jump),
        .mem_rdata_i  (mem_rdata),
        .int_assert_i (int_assert),
        .int_addr_i   (int_addr),
        .mem_raddr_o  (mem_raddr),
        .mem_waddr_o  (mem_waddr),
        .mem_wdata_o  (mem_wdata),
        .mem_we_o     (mem_we),
        .mem_req_o    (mem_req),
        .reg_we_o     (reg_we_q),
        .reg_waddr_o  (reg_waddr_q),
        .reg_wdata_o  (reg_wdata_q),
        .jump_flag_o  (jump_flag),
        .jump_addr_o  (jump_addr)
    );

    tb_exec_checker checker_inst (
        .clk_i (clk), .rst_n_i (rst_n), .exp_valid_i (exp_valid),
        .exp_mem_raddr_i (exp_mem_raddr), .exp_mem_waddr_i (exp_mem_waddr),
        .exp_mem_wdata_i (exp_mem_wdata), .exp_mem_we_i (exp_mem_we),
        .exp_mem_req_i (exp_mem_req), .exp_reg_we_i (exp_reg_we),
        .exp_reg_waddr_i (exp_reg_waddr), .exp_reg_wdata_i (exp_reg_wdata),
        .exp_jump_flag_i (exp_jump_flag), .exp_jump_addr_i (exp_jump_addr),
        .mem_raddr_i (mem_raddr), .mem_waddr_i (mem_waddr), .mem_wdata_i (mem_wdata),
        .mem_we_i (mem_we), .mem_req_i (mem_req), .reg_we_i (reg_we_q),
        .reg_waddr_i (reg_waddr_q), .reg_wdata_i (reg_wdata_q),
        .jump_flag_i (jump_flag), .jump_addr_i (jump_addr),
        .mem_errors_o (mem_errors), .ret_errors_o (ret_errors)
    );

    task automatic drive_idle();
        inst = '0;
        inst.r.opcode = `INST_NOP;
        {reg_we, reg_waddr, int_assert} = '0;
        {reg1_rdata, reg2_rdata, op1, op2} = '0;
        {op1_jump, op2_jump, mem_rdata, int_addr} = '0;
        exp_valid = 1'b0;
        {exp_mem_raddr, exp_mem_waddr, exp_mem_wdata, exp_mem_we, exp_mem_req} = '0;
        {exp_reg_we, exp_reg_waddr, exp_reg_wdata, exp_jump_flag, exp_jump_addr} = '0;
    endtask

    task automatic drive_vector(input int n);
        int b;
        b = n * WORDS;
        inst          = vec_mem[b];
        int_assert    = vec_mem[b+1][12];
        reg_we        = vec_mem[b+1][8];
        reg_waddr     = vec_mem[b+1][4:0];
        reg1_rdata    = vec_mem[b+2];
        reg2_rdata    = vec_mem[b+3];
        op1           = vec_mem[b+4];
        op2           = vec_mem[b+5];
        op1_jump      = vec_mem[b+6];
        op2_jump      = vec_mem[b+7];
        mem_rdata     = vec_mem[b+8];
        int_addr      = vec_mem[b+9];
        exp_valid     = 1'b1;
        exp_mem_raddr = vec_mem[b+10];
        exp_mem_waddr = vec_mem[b+11];
        exp_mem_wdata = vec_mem[b+12];
        exp_jump_flag = vec_mem[b+13][12];
        exp_reg_we    = vec_mem[b+13][8];
        exp_mem_we    = vec_mem[b+13][4];
        exp_mem_req   = vec_mem[b+13][0];
        exp_reg_waddr = vec_mem[b+1][4:0];   // retire holds the decode address
        exp_reg_wdata = vec_mem[b+14];
        exp_jump_addr = vec_mem[b+15];
    endtask

    task automatic finish_run(input logic aborted);
        $display("errors: memory %0d, retire %0d, aborted %0d", mem_errors, ret_errors, aborted);
        if (!aborted && mem_errors == 0 && ret_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycle_limit == 0) begin
            @(posedge clk);
        end
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", cycle_limit);
        finish_run(1'b1);
    end

    initial begin
        int n;
        drive_idle();
        reg_we = 1'b1;                       // stale decode write under reset
        reg_waddr = 5'h1f;
        rst_n = 1'b0;
        $readmemh("exec_input.txt", vec_mem);
        while (num_vec < MAX_VEC && vec_mem[num_vec*WORDS] !== 32'hffffffff) begin
            num_vec++;                       // end marker line stops the count
        end
        cycle_limit = num_vec + 20;
        if (num_vec == 0 || num_vec == MAX_VEC) begin
            $display("exec_input.txt has no vectors or no end marker line");
            finish_run(1'b1);
        end else begin
            @(posedge clk);
            #10 int_assert = 1'b1;           // interrupt under reset
            int_addr = 32'h0000_0080;
            repeat (2) @(posedge clk);
            #10 drive_idle();
            rst_n = 1'b1;
            for (n = 0; n < num_vec; n++) begin
                @(posedge clk);
                #10 drive_vector(n);
            end
            @(posedge clk);
            #10 drive_idle();
            @(posedge clk);
            finish_run(1'b0);
        end
    end

endmodule

`default_nettype wire

//--- tb_exec_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module tb_exec_checker (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             exp_valid_i,
    input  logic [`XLEN-1:0] exp_mem_raddr_i,
    input  logic [`XLEN-1:0] exp_mem_waddr_i,
    input  logic [`XLEN-1:0] exp_mem_wdata_i,
    input  logic             exp_mem_we_i,
    input  logic             exp_mem_req_i,
    input  logic             exp_reg_we_i,
    input  logic [4:0]       exp_reg_waddr_i,
    input  logic [`XLEN-1:0] exp_reg_wdata_i,
    input  logic             exp_jump_flag_i,
    input  logic [`XLEN-1:0] exp_jump_addr_i,
    input  logic [`XLEN-1:0] mem_raddr_i,
    input  logic [`XLEN-1:0] mem_waddr_i,
    input  logic [`XLEN-1:0] mem_wdata_i,
    input  logic             mem_we_i,
    input  logic             mem_req_i,
    input  logic             reg_we_i,
    input  logic [4:0]       reg_waddr_i,
    input  logic [`XLEN-1:0] reg_wdata_i,
    input  logic             jump_flag_i,
    input  logic [`XLEN-1:0] jump_addr_i,
    output int               mem_errors_o,
    output int               ret_errors_o
);

    int               mem_errors = 0;
    int               ret_errors = 0;
    logic             prev_reg_we = 1'b0;     // retire expectation of last vector
    logic [4:0]       prev_reg_waddr = '0;
    logic [`XLEN-1:0] prev_reg_wdata = '0;
    logic             prev_jump_flag = 1'b0;
    logic [`XLEN-1:0] prev_jump_addr = '0;

    assign mem_errors_o = mem_errors;
    assign ret_errors_o = ret_errors;

    function automatic int report_diff(input string name, input logic [31:0] got,
                                       input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
            return 1;
        end
        return 0;
    endfunction

    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            ret_errors += report_diff("reg_we_o in reset", 32'(reg_we_i), 32'h0);
            ret_errors += report_diff("jump_flag_o in reset", 32'(jump_flag_i), 32'h0);
            {prev_reg_we, prev_reg_waddr, prev_reg_wdata} = '0;
            {prev_jump_flag, prev_jump_addr} = '0;
        end else begin
            ret_errors += report_diff("reg_we_o", 32'(reg_we_i), 32'(prev_reg_we));
            ret_errors += report_diff("reg_waddr_o", 32'(reg_waddr_i), 32'(prev_reg_waddr));
            ret_errors += report_diff("reg_wdata_o", reg_wdata_i, prev_reg_wdata);
            ret_errors += report_diff("jump_flag_o", 32'(jump_flag_i), 32'(prev_jump_flag));
            ret_errors += report_diff("jump_addr_o", jump_addr_i, prev_jump_addr);
            if (exp_valid_i) begin
                mem_errors += report_diff("mem_raddr_o", mem_raddr_i, exp_mem_raddr_i);
                mem_errors += report_diff("mem_waddr_o", mem_waddr_i, exp_mem_waddr_i);
                mem_errors += report_diff("mem_wdata_o", mem_wdata_i, exp_mem_wdata_i);
                mem_errors += report_diff("mem_we_o", 32'(mem_we_i), 32'(exp_mem_we_i));
                mem_errors += report_diff("mem_req_o", 32'(mem_req_i), 32'(exp_mem_req_i));
                prev_reg_we    = exp_reg_we_i;
                prev_reg_waddr = exp_reg_waddr_i;
                prev_reg_wdata = exp_reg_wdata_i;
                prev_jump_flag = exp_jump_flag_i;
                prev_jump_addr = exp_jump_addr_i;
            end else begin
                {prev_reg_we, prev_reg_waddr, prev_reg_wdata} = '0;   // idle nop retires zeros
                {prev_jump_flag, prev_jump_addr} = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- exec_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_exec_pkg::rv_inst_u inst_i,
    input  logic                  reg_we_i,
    input  logic [4:0]            reg_waddr_i,
    input  logic [`XLEN-1:0]      reg1_rdata_i,
    input  logic [`XLEN-1:0]      reg2_rdata_i,
    input  logic [`XLEN-1:0]      op1_i,
    input  logic [`XLEN-1:0]      op2_i,
    input  logic [`XLEN-1:0]      op1_jump_i,
    input  logic [`XLEN-1:0]      op2_jump_i,
    input  logic [`XLEN-1:0]      mem_rdata_i,
    input  logic                  int_assert_i,
    input  logic [`XLEN-1:0]      int_addr_i,
    output logic [`XLEN-1:0]      mem_raddr_o,
    output logic [`XLEN-1:0]      mem_waddr_o,
    output logic [`XLEN-1:0]      mem_wdata_o,
    output logic                  mem_we_o,
    output logic                  mem_req_o,
    output logic                  reg_we_o,
    output logic [4:0]            reg_waddr_o,
    output logic [`XLEN-1:0]      reg_wdata_o,
    output logic                  jump_flag_o,
    output logic [`XLEN-1:0]      jump_addr_o
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0] alu_result;
    logic             lt_signed;
    logic             lt_unsigned;
    logic             eq;
    logic [`XLEN-1:0] load_data;
    logic             is_load;
    logic             jump_taken;
    logic [`XLEN-1:0] jump_target;

    exec_alu alu_inst (
        .inst_i        (inst_i),
        .reg1_rdata_i  (reg1_rdata_i),
        .reg2_rdata_i  (reg2_rdata_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .alu_result_o  (alu_result),
        .lt_signed_o   (lt_signed),
        .lt_unsigned_o (lt_unsigned),
        .eq_o          (eq)
    );

    exec_branch branch_inst (
        .inst_i        (inst_i),
        .op1_jump_i    (op1_jump_i),
        .op2_jump_i    (op2_jump_i),
        .lt_signed_i   (lt_signed),
        .lt_unsigned_i (lt_unsigned),
        .eq_i          (eq),
        .int_assert_i  (int_assert_i),
        .int_addr_i    (int_addr_i),
        .jump_taken_o  (jump_taken),
        .jump_target_o (jump_target)
    );

    // memory side stays combinational
    exec_lsu lsu_inst (
        .inst_i       (inst_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .reg2_rdata_i (reg2_rdata_i),
        .mem_rdata_i  (mem_rdata_i),
        .int_assert_i (int_assert_i),
        .mem_raddr_o  (mem_raddr_o),
        .mem_waddr_o  (mem_waddr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_we_o     (mem_we_o),
        .mem_req_o    (mem_req_o),
        .load_data_o  (load_data),
        .is_load_o    (is_load)
    );

    exec_retire retire_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .reg_we_i      (reg_we_i),
        .reg_waddr_i   (reg_waddr_i),
        .is_load_i     (is_load),
        .load_data_i   (load_data),
        .alu_result_i  (alu_result),
        .jump_taken_i  (jump_taken),
        .jump_target_i (jump_target),
        .int_assert_i  (int_assert_i),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .reg_wdata_o   (reg_wdata_o),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o)
    );

endmodule

`default_nettype wire

//--- exec_retire.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_retire (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             reg_we_i,
    input  logic [4:0]       reg_waddr_i,
    input  logic             is_load_i,
    input  logic [`XLEN-1:0] load_data_i,
    input  logic [`XLEN-1:0] alu_result_i,
    input  logic             jump_taken_i,
    input  logic [`XLEN-1:0] jump_target_i,
    input  logic             int_assert_i,
    output logic             reg_we_o,
    output logic [4:0]       reg_waddr_o,
    output logic [`XLEN-1:0] reg_wdata_o,
    output logic             jump_flag_o,
    output logic [`XLEN-1:0] jump_addr_o
);

    logic [`XLEN-1:0] wdata_next;
    logic             we_next;

    assign wdata_next = is_load_i ? load_data_i : alu_result_i;
    assign we_next = reg_we_i & ~int_assert_i;     // no writeback on interrupt

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            reg_we_o    <= we_next;
            reg_waddr_o <= reg_waddr_i;
            reg_wdata_o <= wdata_next;
            jump_flag_o <= jump_taken_i;
            jump_addr_o <= jump_target_i;
        end
    end

endmodule

`default_nettype wire

//--- exec_lsu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_lsu (
    input  rv_exec_pkg::rv_inst_u inst_i,
    input  logic [`XLEN-1:0]      op1_i,
    input  logic [`XLEN-1:0]      op2_i,
    input  logic [`XLEN-1:0]      reg2_rdata_i,
    input  logic [`XLEN-1:0]      mem_rdata_i,
    input  logic                  int_assert_i,
    output logic [`XLEN-1:0]      mem_raddr_o,
    output logic [`XLEN-1:0]      mem_waddr_o,
    output logic [`XLEN-1:0]      mem_wdata_o,
    output logic                  mem_we_o,
    output logic                  mem_req_o,
    output logic [`XLEN-1:0]      load_data_o,
    output logic                  is_load_o
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0] addr;
    logic [1:0]       lane;
    logic             is_store;
    logic [7:0]       rd_byte;
    logic [15:0]      rd_half;

    assign addr = op1_i + op2_i;
    assign lane = addr[1:0];

    always_comb begin
        is_load_o = 1'b0;
        if (inst_i.i.opcode == `INST_TYPE_L) begin
            case (inst_i.i.funct3)
                `INST_LB, `INST_LH, `INST_LW, `INST_LBU, `INST_LHU: is_load_o = 1'b1;
                default: is_load_o = 1'b0;
            endcase
        end
    end

    always_comb begin
        is_store = 1'b0;
        if (inst_i.s.opcode == `INST_TYPE_S) begin
            case (inst_i.s.funct3)
                `INST_SB, `INST_SH, `INST_SW: is_store = 1'b1;
                default: is_store = 1'b0;
            endcase
        end
    end

    // stores read the word too, for the lane merge
    assign mem_raddr_o = (is_load_o || is_store) ? addr : '0;
    assign mem_waddr_o = is_store ? addr : '0;
    assign mem_we_o = is_store & ~int_assert_i;
    assign mem_req_o = (is_load_o | is_store) & ~int_assert_i;

    assign rd_byte = mem_rdata_i[{lane, 3'b000} +: 8];
    assign rd_half = mem_rdata_i[{lane[1], 4'b0000} +: 16];   // half lanes 0 and 2

    always_comb begin
        load_data_o = '0;
        if (is_load_o) begin
            case (inst_i.i.funct3)
                `INST_LB:  load_data_o = {{24{rd_byte[7]}}, rd_byte};
                `INST_LH:  load_data_o = {{16{rd_half[15]}}, rd_half};
                `INST_LW:  load_data_o = mem_rdata_i;
                `INST_LBU: load_data_o = {24'h0, rd_byte};
                `INST_LHU: load_data_o = {16'h0, rd_half};
                default:   load_data_o = '0;
            endcase
        end
    end

    always_comb begin
        mem_wdata_o = '0;
        if (is_store) begin
            mem_wdata_o = mem_rdata_i;     // untouched lanes keep old data
            case (inst_i.s.funct3)
                `INST_SB: mem_wdata_o[{lane, 3'b000} +: 8] = reg2_rdata_i[7:0];
                `INST_SH: mem_wdata_o[{lane[1], 4'b0000} +: 16] = reg2_rdata_i[15:0];
                `INST_SW: mem_wdata_o = reg2_rdata_i;
                default: mem_wdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- exec_branch.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_branch (
    input  rv_exec_pkg::rv_inst_u inst_i,
    input  logic [`XLEN-1:0]      op1_jump_i,
    input  logic [`XLEN-1:0]      op2_jump_i,
    input  logic                  lt_signed_i,
    input  logic                  lt_unsigned_i,
    input  logic                  eq_i,
    input  logic                  int_assert_i,
    input  logic [`XLEN-1:0]      int_addr_i,
    output logic                  jump_taken_o,
    output logic [`XLEN-1:0]      jump_target_o
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0] target_sum;
    logic             cond;

    assign target_sum = op1_jump_i + op2_jump_i;

    always_comb begin
        cond = 1'b0;
        case (inst_i.r.opcode)
            `INST_TYPE_B: begin
                case (inst_i.r.funct3)
                    `INST_BEQ:  cond = eq_i;
                    `INST_BNE:  cond = ~eq_i;
                    `INST_BLT:  cond = lt_signed_i;
                    `INST_BGE:  cond = ~lt_signed_i;
                    `INST_BLTU: cond = lt_unsigned_i;
                    `INST_BGEU: cond = ~lt_unsigned_i;
                    default:    cond = 1'b0;
                endcase
            end
            `INST_JAL, `INST_JALR, `INST_FENCE: begin
                cond = 1'b1;               // fence refetches from the next pc
            end
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    // interrupt wins over any branch
    assign jump_taken_o = cond | int_assert_i;
    assign jump_target_o = int_assert_i ? int_addr_i : (cond ? target_sum : '0);

endmodule

`default_nettype wire

//--- exec_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_alu (
    input  rv_exec_pkg::rv_inst_u inst_i,
    input  logic [`XLEN-1:0]      reg1_rdata_i,
    input  logic [`XLEN-1:0]      reg2_rdata_i,
    input  logic [`XLEN-1:0]      op1_i,
    input  logic [`XLEN-1:0]      op2_i,
    output logic [`XLEN-1:0]      alu_result_o,
    output logic                  lt_signed_o,
    output logic                  lt_unsigned_o,
    output logic                  eq_o
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0]    sum;
    logic [`SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]    srl_res;
    logic [`XLEN-1:0]    sra_res;
    logic                alt;
    logic                r_ok;

    assign sum = op1_i + op2_i;            // add, link and upper-immediate

    assign lt_signed_o = $signed(op1_i) < $signed(op2_i);
    assign lt_unsigned_o = op1_i < op2_i;
    assign eq_o = (op1_i == op2_i);

    assign shamt = (inst_i.r.opcode == `INST_TYPE_I) ? inst_i.i.imm[`SHAMT_W-1:0]
                                                     : reg2_rdata_i[`SHAMT_W-1:0];
    assign srl_res = reg1_rdata_i >> shamt;
    assign sra_res = $signed(reg1_rdata_i) >>> shamt;   // sign fill from reg1

    assign alt = (inst_i.r.funct7 == `FUNCT7_ALT);
    assign r_ok = (inst_i.r.funct7 == `FUNCT7_BASE) || alt;

    always_comb begin
        alu_result_o = '0;
        case (inst_i.r.opcode)
            `INST_TYPE_I: begin
                case (inst_i.i.funct3)
                    `INST_ADDI:  alu_result_o = sum;
                    `INST_SLTI:  alu_result_o = {{(`XLEN-1){1'b0}}, lt_signed_o};
                    `INST_SLTIU: alu_result_o = {{(`XLEN-1){1'b0}}, lt_unsigned_o};
                    `INST_XORI:  alu_result_o = op1_i ^ op2_i;
                    `INST_ORI:   alu_result_o = op1_i | op2_i;
                    `INST_ANDI:  alu_result_o = op1_i & op2_i;
                    `INST_SLLI:  alu_result_o = reg1_rdata_i << shamt;
                    `INST_SRI:   alu_result_o = inst_i.i.imm[10] ? sra_res : srl_res;
                    default:     alu_result_o = '0;
                endcase
            end
            `INST_TYPE_R: begin
                if (r_ok) begin
                    case (inst_i.r.funct3)
                        `INST_ADD_SUB: alu_result_o = alt ? (op1_i - op2_i) : sum;
                        `INST_SLL:     alu_result_o = reg1_rdata_i << shamt;
                        `INST_SLT:     alu_result_o = {{(`XLEN-1){1'b0}}, lt_signed_o};
                        `INST_SLTU:    alu_result_o = {{(`XLEN-1){1'b0}}, lt_unsigned_o};
                        `INST_XOR:     alu_result_o = op1_i ^ op2_i;
                        `INST_SR:      alu_result_o = alt ? sra_res : srl_res;
                        `INST_OR:      alu_result_o = op1_i | op2_i;
                        `INST_AND:     alu_result_o = op1_i & op2_i;
                        default:       alu_result_o = '0;
                    endcase
                end
            end
            `INST_JAL, `INST_JALR, `INST_LUI, `INST_AUIPC: begin
                alu_result_o = sum;        // link address or upper immediate
            end
            default: begin
                alu_result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;       // shamt in [4:0], bit 30 in [10]
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } rv_inst_u;

endpackage

`default_nettype wire

//--- exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define XLEN            32
`define SHAMT_W         5

// major opcodes
`define INST_TYPE_I     7'b0010011
`define INST_TYPE_R     7'b0110011
`define INST_TYPE_L     7'b0000011
`define INST_TYPE_S     7'b0100011
`define INST_TYPE_B     7'b1100011
`define INST_JAL        7'b1101111
`define INST_JALR       7'b1100111
`define INST_LUI        7'b0110111
`define INST_AUIPC      7'b0010111
`define INST_NOP        7'b0000001
`define INST_FENCE      7'b0001111

// I-type funct3
`define INST_ADDI       3'b000
`define INST_SLTI       3'b010
`define INST_SLTIU      3'b011
`define INST_XORI       3'b100
`define INST_ORI        3'b110
`define INST_ANDI       3'b111
`define INST_SLLI       3'b001
`define INST_SRI        3'b101

// R-type funct3
`define INST_ADD_SUB    3'b000
`define INST_SLL        3'b001
`define INST_SLT        3'b010
`define INST_SLTU       3'b011
`define INST_XOR        3'b100
`define INST_SR         3'b101
`define INST_OR         3'b110
`define INST_AND        3'b111

// load and store funct3
`define INST_LB         3'b000
`define INST_LH         3'b001
`define INST_LW         3'b010
`define INST_LBU        3'b100
`define INST_LHU        3'b101
`define INST_SB         3'b000
`define INST_SH         3'b001
`define INST_SW         3'b010

// branch funct3
`define INST_BEQ        3'b000
`define INST_BNE        3'b001
`define INST_BLT        3'b100
`define INST_BGE        3'b101
`define INST_BLTU       3'b110
`define INST_BGEU       3'b111

`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000

`endif
